// ==== src/matrix_pkg.sv ====
`default_nettype none

package matrix_pkg;

  // --------------------
  // Matrix shape
  // --------------------

  // Largest row or column count
  localparam int MAX_DIM = 5;
  // Row and column count width
  localparam int DIM_W = 3;

  // --------------------
  // Data widths
  // --------------------

  // Signed input element, also used for the scalar
  localparam int ELEM_W = 8;
  // Full precision operand and result
  localparam int RES_W = 32;
  // Execution cycle counter
  localparam int CYC_W = 32;

endpackage

`default_nettype wire

// ==== src/alu_op_pkg.sv ====
`default_nettype none

package alu_op_pkg;

  // Operation codes
  localparam int OP_W = 3;
  localparam logic [OP_W-1:0] OP_ADD        = 3'd0;
  localparam logic [OP_W-1:0] OP_SCALAR_MUL = 3'd1;
  localparam logic [OP_W-1:0] OP_TRANSPOSE  = 3'd2;
  localparam logic [OP_W-1:0] OP_MAT_MUL    = 3'd3;

  // Width of the i, j and k loop counters
  localparam int IDX_W = 3;

  // Controller state encoding
  localparam int ST_W = 3;
  localparam logic [ST_W-1:0] ST_IDLE    = 3'd0;
  localparam logic [ST_W-1:0] ST_EXEC    = 3'd1;
  localparam logic [ST_W-1:0] ST_ACCUM   = 3'd2;
  localparam logic [ST_W-1:0] ST_WAIT_TX = 3'd3;
  localparam logic [ST_W-1:0] ST_DONE    = 3'd4;

endpackage

`default_nettype wire

// ==== src/alu_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_ctrl
  import matrix_pkg::*;
  import alu_op_pkg::*;
(
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             start_i,
  input  wire logic [OP_W-1:0]  op_code_i,
  input  wire logic [DIM_W-1:0] a_rows_i,
  input  wire logic [DIM_W-1:0] a_cols_i,
  input  wire logic [DIM_W-1:0] b_rows_i,
  input  wire logic [DIM_W-1:0] b_cols_i,
  input  wire logic             accepted_i,
  output logic [IDX_W-1:0]      idx_i_o,
  output logic [IDX_W-1:0]      idx_j_o,
  output logic [IDX_W-1:0]      idx_k_o,
  output logic                  fetch_en_o,
  output logic                  mul_en_o,
  output logic                  acc_en_o,
  output logic                  acc_clr_o,
  output logic                  direct_o,
  output logic                  load_en_o,
  output logic                  last_col_o,
  output logic                  done_o,
  output logic                  error_o,
  output logic [CYC_W-1:0]      cycle_cnt_o
);

  logic [ST_W-1:0]  state_q;
  logic [IDX_W-1:0] idx_i_q, idx_j_q, idx_k_q;
  logic [IDX_W-1:0] lim_i_q, lim_j_q, lim_k_q;
  // 0 fetch, 1 execute; in ACCUM 0 multiply, 1 accumulate
  logic             phase_q;
  // Scalar and matrix multiply go through the MAC
  logic             mul_path_q;
  logic             dim_err_q;

  logic last_j, last_i, k_done;
  logic a_in_range, b_in_range;
  logic add_ok, mul_ok;

  function automatic logic dim_ok(input logic [DIM_W-1:0] d);
    return (d != '0) && (d <= DIM_W'(MAX_DIM));
  endfunction

  // --------------------
  // Dimension checks
  // --------------------
  assign a_in_range = dim_ok(a_rows_i) && dim_ok(a_cols_i);
  assign b_in_range = dim_ok(b_rows_i) && dim_ok(b_cols_i);
  // Add needs equal shapes
  assign add_ok = a_in_range && (a_rows_i == b_rows_i) && (a_cols_i == b_cols_i);
  // Multiply needs A columns equal to B rows
  assign mul_ok = a_in_range && b_in_range && (a_cols_i == b_rows_i);

  assign last_j = (idx_j_q == lim_j_q - 1'b1);
  assign last_i = (idx_i_q == lim_i_q - 1'b1);
  assign k_done = (idx_k_q == lim_k_q);

  assign idx_i_o = idx_i_q;
  assign idx_j_o = idx_j_q;
  assign idx_k_o = idx_k_q;

  // --------------------
  // Datapath strobes
  // --------------------
  always_comb begin
    fetch_en_o = 1'b0;
    mul_en_o   = 1'b0;
    acc_en_o   = 1'b0;
    acc_clr_o  = 1'b0;
    direct_o   = 1'b0;
    load_en_o  = 1'b0;
    last_col_o = 1'b0;
    case (state_q)
      // Keep the accumulator empty between operations
      ST_IDLE: acc_clr_o = 1'b1;
      ST_EXEC: begin
        if (!mul_path_q) begin
          // Add and transpose: fetch, then sum and load
          if (!phase_q) begin
            fetch_en_o = 1'b1;
          end else begin
            direct_o   = 1'b1;
            load_en_o  = 1'b1;
            last_col_o = last_j;
          end
        end else if (k_done) begin
          // Writeback; stream samples accumulator before it clears
          load_en_o  = 1'b1;
          acc_clr_o  = 1'b1;
          last_col_o = last_j;
        end else begin
          fetch_en_o = 1'b1;
        end
      end
      ST_ACCUM: begin
        if (!phase_q) begin
          mul_en_o = 1'b1;
        end else begin
          acc_en_o = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // --------------------
  // State and counters
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= ST_IDLE;
      idx_i_q     <= '0;
      idx_j_q     <= '0;
      idx_k_q     <= '0;
      lim_i_q     <= '0;
      lim_j_q     <= '0;
      lim_k_q     <= '0;
      phase_q     <= 1'b0;
      mul_path_q  <= 1'b0;
      dim_err_q   <= 1'b0;
      done_o      <= 1'b0;
      error_o     <= 1'b0;
      cycle_cnt_o <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          done_o <= 1'b0;
          if (start_i) begin
            error_o     <= 1'b0;
            cycle_cnt_o <= '0;
            idx_i_q     <= '0;
            idx_j_q     <= '0;
            idx_k_q     <= '0;
            phase_q     <= 1'b0;
            dim_err_q   <= 1'b0;
            mul_path_q  <= 1'b0;
            // Default loop shape is A, one round per element
            lim_i_q     <= IDX_W'(a_rows_i);
            lim_j_q     <= IDX_W'(a_cols_i);
            lim_k_q     <= IDX_W'(1);
            state_q     <= ST_EXEC;
            case (op_code_i)
              OP_ADD: begin
                if (!add_ok) begin
                  dim_err_q <= 1'b1;
                  state_q   <= ST_DONE;
                end
              end
              OP_SCALAR_MUL: begin
                mul_path_q <= 1'b1;
                if (!a_in_range) begin
                  dim_err_q <= 1'b1;
                  state_q   <= ST_DONE;
                end
              end
              OP_TRANSPOSE: begin
                // Output is A columns by A rows
                lim_i_q <= IDX_W'(a_cols_i);
                lim_j_q <= IDX_W'(a_rows_i);
                if (!a_in_range) begin
                  dim_err_q <= 1'b1;
                  state_q   <= ST_DONE;
                end
              end
              OP_MAT_MUL: begin
                mul_path_q <= 1'b1;
                lim_j_q    <= IDX_W'(b_cols_i);
                // Common dimension sets the dot product length
                lim_k_q    <= IDX_W'(a_cols_i);
                if (!mul_ok) begin
                  dim_err_q <= 1'b1;
                  state_q   <= ST_DONE;
                end
              end
              // Unsupported code, finish without error
              default: state_q <= ST_DONE;
            endcase
          end
        end
        ST_EXEC: begin
          cycle_cnt_o <= cycle_cnt_o + 1'b1;
          if (!mul_path_q) begin
            phase_q <= ~phase_q;
            if (phase_q) state_q <= ST_WAIT_TX;
          end else if (k_done) begin
            idx_k_q <= '0;
            state_q <= ST_WAIT_TX;
          end else begin
            phase_q <= 1'b0;
            state_q <= ST_ACCUM;
          end
        end
        ST_ACCUM: begin
          // Multiply then accumulate, both outside EXEC
          phase_q <= ~phase_q;
          if (phase_q) begin
            idx_k_q <= idx_k_q + 1'b1;
            state_q <= ST_EXEC;
          end
        end
        ST_WAIT_TX: begin
          // Step j then i once the element is taken
          if (accepted_i) begin
            if (last_j) begin
              idx_j_q <= '0;
              if (last_i) begin
                state_q <= ST_DONE;
              end else begin
                idx_i_q <= idx_i_q + 1'b1;
                state_q <= ST_EXEC;
              end
            end else begin
              idx_j_q <= idx_j_q + 1'b1;
              state_q <= ST_EXEC;
            end
          end
        end
        ST_DONE: begin
          done_o  <= 1'b1;
          error_o <= dim_err_q;
          // Hold done until start is released
          if (done_o && !start_i) begin
            done_o  <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/operand_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module operand_fetch
  import matrix_pkg::*;
  import alu_op_pkg::*;
(
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,
  input  wire logic                                         fetch_en_i,
  input  wire logic [OP_W-1:0]                              op_code_i,
  input  wire logic [IDX_W-1:0]                             idx_i_i,
  input  wire logic [IDX_W-1:0]                             idx_j_i,
  input  wire logic [IDX_W-1:0]                             idx_k_i,
  input  wire logic [MAX_DIM-1:0][MAX_DIM-1:0][ELEM_W-1:0] mat_a_i,
  input  wire logic [MAX_DIM-1:0][MAX_DIM-1:0][ELEM_W-1:0] mat_b_i,
  input  wire logic [ELEM_W-1:0]                            scalar_i,
  output logic signed [RES_W-1:0]                           op_a_o,
  output logic signed [RES_W-1:0]                           op_b_o
);

  logic signed [RES_W-1:0] a_sel, b_sel;

  // Sign-extend one element to result width
  function automatic logic signed [RES_W-1:0] sext(input logic [ELEM_W-1:0] e);
    return RES_W'(signed'(e));
  endfunction

  // --------------------
  // Operand routing
  // --------------------
  always_comb begin
    a_sel = '0;
    b_sel = '0;
    case (op_code_i)
      OP_ADD: begin
        a_sel = sext(mat_a_i[idx_i_i][idx_j_i]);
        b_sel = sext(mat_b_i[idx_i_i][idx_j_i]);
      end
      // Zero B lets the sum path pass A through
      OP_TRANSPOSE: a_sel = sext(mat_a_i[idx_j_i][idx_i_i]);
      OP_SCALAR_MUL: begin
        a_sel = sext(mat_a_i[idx_i_i][idx_j_i]);
        b_sel = sext(scalar_i);
      end
      // Row of A against column of B
      OP_MAT_MUL: begin
        a_sel = sext(mat_a_i[idx_i_i][idx_k_i]);
        b_sel = sext(mat_b_i[idx_k_i][idx_j_i]);
      end
      default: ;
    endcase
  end

  // Fetch stage register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_a_o <= '0;
      op_b_o <= '0;
    end else if (fetch_en_i) begin
      op_a_o <= a_sel;
      op_b_o <= b_sel;
    end
  end

endmodule

`default_nettype wire

// ==== src/mac_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mac_unit
  import matrix_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic signed [RES_W-1:0] op_a_i,
  input  wire logic signed [RES_W-1:0] op_b_i,
  input  wire logic                    mul_en_i,
  input  wire logic                    acc_en_i,
  input  wire logic                    acc_clr_i,
  input  wire logic                    direct_i,
  output logic signed [RES_W-1:0]      result_o
);

  logic signed [RES_W-1:0] prod_q;
  logic signed [RES_W-1:0] acc_q;

  // --------------------
  // Multiply stage
  // --------------------
  // Single multiplier shared by scalar and matrix multiply
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prod_q <= '0;
    end else if (mul_en_i) begin
      prod_q <= op_a_i * op_b_i;
    end
  end

  // --------------------
  // Accumulate stage
  // --------------------
  // Clear wins over accumulate
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= '0;
    end else if (acc_clr_i) begin
      acc_q <= '0;
    end else if (acc_en_i) begin
      acc_q <= acc_q + prod_q;
    end
  end

  // Direct sum for add and transpose, else dot product
  assign result_o = direct_i ? (op_a_i + op_b_i) : acc_q;

endmodule

`default_nettype wire

// ==== src/stream_out.sv ====
`timescale 1ns/1ns
`default_nettype none

module stream_out
  import matrix_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    load_en_i,
  input  wire logic signed [RES_W-1:0] result_i,
  input  wire logic                    last_col_i,
  input  wire logic                    stream_ready_i,
  output logic                         stream_valid_o,
  output logic signed [RES_W-1:0]      stream_data_o,
  output logic                         stream_last_col_o,
  output logic                         accepted_o
);

  // Element leaves on ready with valid
  assign accepted_o = stream_valid_o & stream_ready_i;

  // --------------------
  // Output hold register
  // --------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stream_valid_o    <= 1'b0;
      stream_data_o     <= '0;
      stream_last_col_o <= 1'b0;
    end else if (load_en_i) begin
      // Capture one result, held until taken
      stream_valid_o    <= 1'b1;
      stream_data_o     <= result_i;
      stream_last_col_o <= last_col_i;
    end else if (accepted_o) begin
      stream_valid_o    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/matrix_alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module matrix_alu_top
  import matrix_pkg::*;
  import alu_op_pkg::*;
(
  input  wire logic                                         clk,
  input  wire logic                                         rst_n,
  input  wire logic                                         start_i,
  input  wire logic [OP_W-1:0]                              op_code_i,
  input  wire logic [MAX_DIM-1:0][MAX_DIM-1:0][ELEM_W-1:0] mat_a_i,
  input  wire logic [DIM_W-1:0]                             a_rows_i,
  input  wire logic [DIM_W-1:0]                             a_cols_i,
  input  wire logic [MAX_DIM-1:0][MAX_DIM-1:0][ELEM_W-1:0] mat_b_i,
  input  wire logic [DIM_W-1:0]                             b_rows_i,
  input  wire logic [DIM_W-1:0]                             b_cols_i,
  input  wire logic [ELEM_W-1:0]                            scalar_i,
  input  wire logic                                         stream_ready_i,
  output logic                                              done_o,
  output logic                                              error_o,
  output logic [CYC_W-1:0]                                  cycle_cnt_o,
  output logic                                              stream_valid_o,
  output logic signed [RES_W-1:0]                           stream_data_o,
  output logic                                              stream_last_col_o
);

  // --------------------
  // Control to datapath
  // --------------------
  logic [IDX_W-1:0] idx_i, idx_j, idx_k;
  logic fetch_en, mul_en, acc_en, acc_clr, direct;
  logic load_en, last_col, accepted;

  // Datapath values
  logic signed [RES_W-1:0] op_a, op_b, result;

  alu_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .op_code_i   (op_code_i),
    .a_rows_i    (a_rows_i),
    .a_cols_i    (a_cols_i),
    .b_rows_i    (b_rows_i),
    .b_cols_i    (b_cols_i),
    .accepted_i  (accepted),
    .idx_i_o     (idx_i),
    .idx_j_o     (idx_j),
    .idx_k_o     (idx_k),
    .fetch_en_o  (fetch_en),
    .mul_en_o    (mul_en),
    .acc_en_o    (acc_en),
    .acc_clr_o   (acc_clr),
    .direct_o    (direct),
    .load_en_o   (load_en),
    .last_col_o  (last_col),
    .done_o      (done_o),
    .error_o     (error_o),
    .cycle_cnt_o (cycle_cnt_o)
  );

  // Operand select and fetch register
  operand_fetch u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .fetch_en_i (fetch_en),
    .op_code_i  (op_code_i),
    .idx_i_i    (idx_i),
    .idx_j_i    (idx_j),
    .idx_k_i    (idx_k),
    .mat_a_i    (mat_a_i),
    .mat_b_i    (mat_b_i),
    .scalar_i   (scalar_i),
    .op_a_o     (op_a),
    .op_b_o     (op_b)
  );

  mac_unit u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_a_i    (op_a),
    .op_b_i    (op_b),
    .mul_en_i  (mul_en),
    .acc_en_i  (acc_en),
    .acc_clr_i (acc_clr),
    .direct_i  (direct),
    .result_o  (result)
  );

  // Ready-gated output stage
  stream_out u_stream (
    .clk               (clk),
    .rst_n             (rst_n),
    .load_en_i         (load_en),
    .result_i          (result),
    .last_col_i        (last_col),
    .stream_ready_i    (stream_ready_i),
    .stream_valid_o    (stream_valid_o),
    .stream_data_o     (stream_data_o),
    .stream_last_col_o (stream_last_col_o),
    .accepted_o        (accepted)
  );

endmodule

`default_nettype wire

// ==== tb/tb_matrix_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_matrix_alu
  import matrix_pkg::*;
  import alu_op_pkg::*;
();

  // Wait limits in clock cycles
  localparam int DONE_LIMIT = 6000;
  localparam int IDLE_LIMIT = 16;
  localparam int N_RANDOM   = 16;

  logic                                        clk;
  logic                                        rst_n;
  logic                                        start_i;
  logic [OP_W-1:0]                             op_code_i;
  logic [MAX_DIM-1:0][MAX_DIM-1:0][ELEM_W-1:0] mat_a_i;
  logic [MAX_DIM-1:0][MAX_DIM-1:0][ELEM_W-1:0] mat_b_i;
  logic [DIM_W-1:0]                            a_rows_i;
  logic [DIM_W-1:0]                            a_cols_i;
  logic [DIM_W-1:0]                            b_rows_i;
  logic [DIM_W-1:0]                            b_cols_i;
  logic [ELEM_W-1:0]                           scalar_i;
  logic                                        stream_ready_i;
  logic                                        done_o;
  logic                                        error_o;
  logic [CYC_W-1:0]                            cycle_cnt_o;
  logic                                        stream_valid_o;
  logic signed [RES_W-1:0]                     stream_data_o;
  logic                                        stream_last_col_o;

  // --------------------
  // Reference model state
  // --------------------
  logic [31:0]              rng;
  logic signed [ELEM_W-1:0] a_m [MAX_DIM][MAX_DIM];
  logic signed [ELEM_W-1:0] b_m [MAX_DIM][MAX_DIM];
  // Expected stream in row-major order
  logic signed [RES_W-1:0]  exp_data [MAX_DIM*MAX_DIM];
  logic                     exp_last [MAX_DIM*MAX_DIM];
  logic [31:0]              exp_count;
  logic [31:0]              exp_cycles;
  logic                     exp_error;
  // Accepted elements, counted over the whole run
  logic [31:0]              rx_cnt;
  logic [31:0]              rx_base;
  logic [31:0]              rx_idx;
  logic signed [RES_W-1:0]  head_data;
  logic                     head_last;
  int                       err_cnt;
  int                       test_cnt;
  int                       test_fail;
  logic                     hung;

  matrix_alu_top u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .start_i           (start_i),
    .op_code_i         (op_code_i),
    .mat_a_i           (mat_a_i),
    .a_rows_i          (a_rows_i),
    .a_cols_i          (a_cols_i),
    .mat_b_i           (mat_b_i),
    .b_rows_i          (b_rows_i),
    .b_cols_i          (b_cols_i),
    .scalar_i          (scalar_i),
    .stream_ready_i    (stream_ready_i),
    .done_o            (done_o),
    .error_o           (error_o),
    .cycle_cnt_o       (cycle_cnt_o),
    .stream_valid_o    (stream_valid_o),
    .stream_data_o     (stream_data_o),
    .stream_last_col_o (stream_last_col_o)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Count elements taken by the sink
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt <= '0;
    end else if (stream_valid_o && stream_ready_i) begin
      rx_cnt <= rx_cnt + 32'd1;
    end
  end

  // Next expected element for this operation
  assign rx_idx = rx_cnt - rx_base;
  always_comb begin
    head_data = '0;
    head_last = 1'b0;
    if (rx_idx < 32'(MAX_DIM * MAX_DIM)) begin
      head_data = exp_data[rx_idx[4:0]];
      head_last = exp_last[rx_idx[4:0]];
    end
  end

  // --------------------
  // Assertions
  // --------------------
  reset_clear: assert property (@(posedge clk)
    !rst_n |-> (!done_o && !error_o && !stream_valid_o && cycle_cnt_o == '0))
    else begin
      $display("Mismatch at %0t: outputs not cleared during reset", $time);
      err_cnt = err_cnt + 1;
    end

  data_check: assert property (@(posedge clk) disable iff (!rst_n)
    (stream_valid_o && stream_ready_i) |->
      (stream_data_o == head_data && stream_last_col_o == head_last))
    else begin
      $display("Mismatch at %0t: element %0d got %0d last %0b, expected %0d last %0b",
               $time, $sampled(rx_idx), $sampled(stream_data_o),
               $sampled(stream_last_col_o), $sampled(head_data), $sampled(head_last));
      err_cnt = err_cnt + 1;
    end

  // Also covers error and unsupported codes where nothing may stream
  no_extra: assert property (@(posedge clk) disable iff (!rst_n)
    stream_valid_o |-> (rx_idx < exp_count))
    else begin
      $display("Stream valid at %0t beyond the %0d expected elements", $time, exp_count);
      err_cnt = err_cnt + 1;
    end

  hold_check: assert property (@(posedge clk) disable iff (!rst_n)
    (stream_valid_o && !stream_ready_i) |=>
      (stream_valid_o && $stable(stream_data_o) && $stable(stream_last_col_o)))
    else begin
      $display("Mismatch at %0t: stream output changed while ready was low", $time);
      err_cnt = err_cnt + 1;
    end

  done_check: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done_o) |->
      (error_o == exp_error && cycle_cnt_o == exp_cycles && rx_idx == exp_count))
    else begin
      $display("Mismatch at %0t: done with error %0b cycles %0d count %0d, expected %0b %0d %0d",
               $time, error_o, cycle_cnt_o, rx_idx, exp_error, exp_cycles, exp_count);
      err_cnt = err_cnt + 1;
    end

  done_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (done_o && start_i) |=> done_o)
    else begin
      $display("Done dropped at %0t while start was still high", $time);
      err_cnt = err_cnt + 1;
    end

  done_release: assert property (@(posedge clk) disable iff (!rst_n)
    (done_o && !start_i) |=> !done_o)
    else begin
      $display("Done stayed high at %0t after start was released", $time);
      err_cnt = err_cnt + 1;
    end

  error_clear: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(start_i) |=> !error_o)
    else begin
      $display("Error flag still set at %0t after a new start", $time);
      err_cnt = err_cnt + 1;
    end

  // --------------------
  // Stimulus helpers
  // --------------------
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Row or column count from 1 to MAX_DIM
  function automatic int rand_dim();
    logic [31:0] r;
    r = next_rand();
    return int'(r % 32'(MAX_DIM)) + 1;
  endfunction

  function automatic string op_name(input logic [OP_W-1:0] op);
    case (op)
      OP_ADD:        return "add";
      OP_SCALAR_MUL: return "scalar_mul";
      OP_TRANSPOSE:  return "transpose";
      OP_MAT_MUL:    return "mat_mul";
      default:       return "unsupported";
    endcase
  endfunction

  // Every cell gets its own random value including unused ones
  task automatic fill_matrices();
    logic [31:0] r;
    for (int i = 0; i < MAX_DIM; i++) begin
      for (int j = 0; j < MAX_DIM; j++) begin
        r = next_rand();
        a_m[i][j] = r[7:0];
        b_m[i][j] = r[15:8];
        mat_a_i[i][j] = r[7:0];
        mat_b_i[i][j] = r[15:8];
      end
    end
  endtask

  // Output shape, elements and EXEC cycles from the operation rules
  task automatic build_expected(input logic [OP_W-1:0] op, input int ar, input int ac,
                                input int br, input int bc);
    int r;
    int c;
    int k;
    int n;
    logic signed [RES_W-1:0] av;
    logic signed [RES_W-1:0] bv;
    logic signed [RES_W-1:0] acc;
    n = 0;
    r = 0;
    c = 0;
    k = 1;
    exp_error = 1'b0;
    case (op)
      OP_ADD: begin
        r = ar;
        c = ac;
        exp_error = (ar != br) || (ac != bc);
      end
      OP_SCALAR_MUL: begin
        r = ar;
        c = ac;
      end
      OP_TRANSPOSE: begin
        r = ac;
        c = ar;
      end
      OP_MAT_MUL: begin
        r = ar;
        c = bc;
        k = ac;
        exp_error = (ac != br);
      end
      default: ;
    endcase
    // Rejected operations stream nothing and spend no EXEC cycles
    if (exp_error) begin
      r = 0;
      c = 0;
    end
    for (int i = 0; i < r; i++) begin
      for (int j = 0; j < c; j++) begin
        acc = '0;
        case (op)
          OP_ADD: begin
            av = a_m[i][j];
            bv = b_m[i][j];
            acc = av + bv;
          end
          OP_TRANSPOSE: acc = a_m[j][i];
          OP_SCALAR_MUL: begin
            av = a_m[i][j];
            bv = signed'(scalar_i);
            acc = av * bv;
          end
          default: begin
            // Dot product of row i of A and column j of B
            for (int kk = 0; kk < k; kk++) begin
              av = a_m[i][kk];
              bv = b_m[kk][j];
              acc = acc + av * bv;
            end
          end
        endcase
        exp_data[n] = acc;
        exp_last[n] = (j == c - 1);
        n++;
      end
    end
    exp_count = 32'(n);
    if (op == OP_ADD || op == OP_TRANSPOSE) begin
      exp_cycles = 32'(2 * r * c);
    end else begin
      exp_cycles = 32'(r * c * (k + 1));
    end
  endtask

  // One operation from start back to idle
  // Called 10 ns after a rising edge
  task automatic run_test(input logic [OP_W-1:0] op, input int ar, input int ac,
                          input int br, input int bc, input logic gaps);
    int cnt;
    int err_before;
    logic [31:0] rnd;
    if (hung) return;
    err_before = err_cnt;
    fill_matrices();
    rnd = next_rand();
    scalar_i = rnd[ELEM_W-1:0];
    op_code_i = op;
    a_rows_i = DIM_W'(ar);
    a_cols_i = DIM_W'(ac);
    b_rows_i = DIM_W'(br);
    b_cols_i = DIM_W'(bc);
    build_expected(op, ar, ac, br, bc);
    rx_base = rx_cnt;
    stream_ready_i = 1'b1;
    start_i = 1'b1;
    cnt = 0;
    while (!done_o && cnt < DONE_LIMIT) begin
      @(posedge clk);
      #10;
      // Roughly one cycle in four without ready
      rnd = next_rand();
      stream_ready_i = gaps ? (rnd[1:0] != 2'b00) : 1'b1;
      cnt++;
    end
    if (!done_o) begin
      hung = 1'b1;
      $display("Timeout: done_o did not rise within %0d cycles", DONE_LIMIT);
    end else begin
      @(posedge clk);
      #10;
      start_i = 1'b0;
      stream_ready_i = 1'b1;
      cnt = 0;
      while (done_o && cnt < IDLE_LIMIT) begin
        @(posedge clk);
        #10;
        cnt++;
      end
      if (done_o) begin
        hung = 1'b1;
        $display("Timeout: done_o stayed high after start_i was released");
      end
      // Let the release checks settle before the verdict
      @(posedge clk);
      #10;
    end
    test_cnt++;
    if (err_cnt != err_before || hung) begin
      test_fail++;
    end
    $display("test %0d %s A %0dx%0d B %0dx%0d: %s", test_cnt, op_name(op), ar, ac, br, bc,
             (err_cnt == err_before && !hung) ? "ok" : "FAILED");
  endtask

  // --------------------
  // Test sequence
  // --------------------
  initial begin
    int ar;
    int ac;
    int bc;
    logic [OP_W-1:0] op;
    rng = 32'h66094a2c;
    rst_n = 1'b0;
    start_i = 1'b0;
    op_code_i = '0;
    mat_a_i = '0;
    mat_b_i = '0;
    a_rows_i = '0;
    a_cols_i = '0;
    b_rows_i = '0;
    b_cols_i = '0;
    scalar_i = '0;
    stream_ready_i = 1'b0;
    exp_count = '0;
    exp_cycles = '0;
    exp_error = 1'b0;
    rx_base = '0;
    err_cnt = 0;
    test_cnt = 0;
    test_fail = 0;
    hung = 1'b0;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(posedge clk);
    #10;

    // Directed shapes with ready always high
    run_test(OP_ADD, 3, 4, 3, 4, 1'b0);
    run_test(OP_TRANSPOSE, 2, 5, 2, 5, 1'b0);
    run_test(OP_SCALAR_MUL, 4, 3, 4, 3, 1'b0);
    run_test(OP_MAT_MUL, 3, 4, 4, 2, 1'b0);
    run_test(OP_MAT_MUL, 5, 5, 5, 5, 1'b0);
    run_test(OP_ADD, 1, 1, 1, 1, 1'b0);

    // Random shapes with ready gaps
    for (int t = 0; t < N_RANDOM; t++) begin
      op = OP_W'(t % 4);
      ar = rand_dim();
      ac = rand_dim();
      bc = (op == OP_MAT_MUL) ? rand_dim() : ac;
      run_test(op, ar, ac, (op == OP_MAT_MUL) ? ac : ar, bc, 1'b1);
    end

    // Shape mismatches and then codes outside the set
    run_test(OP_ADD, 2, 3, 2, 4, 1'b0);
    run_test(OP_MAT_MUL, 3, 2, 3, 3, 1'b0);
    for (int code = 4; code < 8; code++) begin
      run_test(OP_W'(code), 2, 2, 2, 2, 1'b0);
    end
    // An error run and then a normal run that must start with error low
    run_test(OP_MAT_MUL, 2, 4, 3, 2, 1'b0);
    run_test(OP_MAT_MUL, 2, 4, 4, 3, 1'b1);

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             test_cnt, test_cnt - test_fail, test_fail, err_cnt);
    if (err_cnt == 0 && test_fail == 0 && !hung) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/matrix_pkg.sv
src/alu_op_pkg.sv
src/alu_ctrl.sv
src/operand_fetch.sv
src/mac_unit.sv
src/stream_out.sv
src/matrix_alu_top.sv
tb/tb_matrix_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the matrix ALU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_matrix_alu -o tb_matrix_alu > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  cat "$BUILD_LOG"
  exit 1
fi

./obj_dir/tb_matrix_alu > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "=== PASS ===" "$SIM_LOG"; then
  exit 0
fi
exit 1
